/* hdl/imul_pkg.sv */
package imul_pkg;

  // operand and result word
  typedef logic [63:0] word_t;

  // opcode, codes 10 to 15 are illegal
  typedef logic [3:0] op_t;

  // {carry, overflow, reserved, sign, zero, parity}
  typedef logic [5:0] flags_t;

  // which part of the product goes to the result
  typedef logic [1:0] res_sel_t;

  // operand with one extra bit for the sign extension
  typedef logic [64:0] ext_t;

  // signed product of two extended operands
  typedef logic [129:0] prod_t;

  localparam op_t OP_MUL64     = 4'd0;
  localparam op_t OP_LMUL64    = 4'd1;
  localparam op_t OP_IMUL64    = 4'd2;
  localparam op_t OP_LIMUL64   = 4'd3;
  localparam op_t OP_MUL32     = 4'd4;
  localparam op_t OP_IMUL32    = 4'd5;
  localparam op_t OP_MUL32_64  = 4'd6;
  localparam op_t OP_IMUL32_64 = 4'd7;
  localparam op_t OP_SWP32     = 4'd8;
  localparam op_t OP_SWP64     = 4'd9;

  localparam res_sel_t SEL_LO   = 2'd0;
  localparam res_sel_t SEL_HI   = 2'd1;
  localparam res_sel_t SEL_LO32 = 2'd2;
  localparam res_sel_t SEL_SWP  = 2'd3;

  // bit positions inside flags_t
  localparam int FLG_CF  = 5;
  localparam int FLG_OF  = 4;
  localparam int FLG_RSV = 3;
  localparam int FLG_SF  = 2;
  localparam int FLG_ZF  = 1;
  localparam int FLG_PF  = 0;

  // register stages of the multiplier array
  localparam int unsigned ARRAY_STAGES = 2;

  typedef struct packed {
    logic     valid;
    ext_t     opa;
    ext_t     opb;
    res_sel_t sel;
    logic     is_signed;
    logic     is_short;
    word_t    swp_res;
  } mul_req_t;

  typedef struct packed {
    logic     valid;
    prod_t    prod;
    res_sel_t sel;
    logic     is_signed;
    logic     is_short;
    word_t    swp_res;
  } mul_prod_t;

endpackage

/* hdl/imul_decode.sv */
module imul_decode (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               clk_en,
  input  logic               en,
  input  imul_pkg::op_t      op,
  input  imul_pkg::word_t    a,
  input  imul_pkg::word_t    b,
  output imul_pkg::mul_req_t req
);
  import imul_pkg::*;

  res_sel_t sel;
  logic     is_signed;
  logic     is_short;
  logic     half;
  logic     swp_half;
  ext_t     opa;
  ext_t     opb;
  word_t    swp64;
  word_t    swp_res;

  // illegal codes take the default branch and run as mul64
  always_comb begin
    sel       = SEL_LO;
    is_signed = 1'b0;
    is_short  = 1'b0;
    half      = 1'b0;
    swp_half  = 1'b0;
    case (op)
      OP_MUL64: sel = SEL_LO;
      OP_IMUL64: is_signed = 1'b1;
      OP_LMUL64: sel = SEL_HI;
      OP_LIMUL64: begin
        sel       = SEL_HI;
        is_signed = 1'b1;
      end
      OP_MUL32: begin
        sel      = SEL_LO32;
        is_short = 1'b1;
        half     = 1'b1;
      end
      OP_IMUL32: begin
        sel       = SEL_LO32;
        is_short  = 1'b1;
        is_signed = 1'b1;
        half      = 1'b1;
      end
      OP_MUL32_64: half = 1'b1;
      OP_IMUL32_64: begin
        is_signed = 1'b1;
        half      = 1'b1;
      end
      OP_SWP32: begin
        sel      = SEL_SWP;
        swp_half = 1'b1;
      end
      OP_SWP64: sel = SEL_SWP;
      default: sel = SEL_LO;
    endcase
  end

  // 65 bit operands, the top bit carries the sign for signed forms
  always_comb begin
    if (half) begin
      opa = {{33{is_signed & a[31]}}, a[31:0]};
      opb = {{33{is_signed & b[31]}}, b[31:0]};
    end else begin
      opa = {is_signed & a[63], a};
      opb = {is_signed & b[63], b};
    end
  end

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      swp64[8*i +: 8] = a[8*(7-i) +: 8];
    end
  end

  // upper half of the full reversal already holds the low 4 bytes reversed
  assign swp_res = swp_half ? {32'b0, swp64[63:32]} : swp64;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req <= '0;
    end else if (clk_en) begin
      req.valid     <= en;
      req.opa       <= opa;
      req.opb       <= opb;
      req.sel       <= sel;
      req.is_signed <= is_signed;
      req.is_short  <= is_short;
      req.swp_res   <= swp_res;
    end
  end

  // the issue stage must never send an undefined opcode
  a_legal_op: assert property (@(posedge clk) disable iff (!arst_n)
    clk_en && en |-> op <= OP_SWP64)
    else $error("imul_decode: illegal opcode %0d", op);

endmodule

/* hdl/imul_array.sv */
module imul_array #(
  parameter int unsigned STAGES = imul_pkg::ARRAY_STAGES
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                clk_en,
  input  imul_pkg::mul_req_t  req,
  output imul_pkg::mul_prod_t prod
);
  import imul_pkg::*;

  // partial products and the control fields riding along
  typedef struct packed {
    logic               valid;
    logic [63:0]        ll;
    logic signed [65:0] lh;
    logic signed [65:0] hl;
    logic signed [65:0] hh;
    res_sel_t           sel;
    logic               is_signed;
    logic               is_short;
    word_t              swp_res;
  } pp_t;

  logic [31:0]         a_lo;
  logic [31:0]         b_lo;
  logic signed [32:0]  a_hi;
  logic signed [32:0]  b_hi;
  logic [63:0]         pp_ll;
  logic signed [65:0]  pp_lh;
  logic signed [65:0]  pp_hl;
  logic signed [65:0]  pp_hh;
  pp_t                 s1;
  logic signed [129:0] sum;
  logic [STAGES-1:0]   ce_trk;

  // low halves unsigned, high halves carry the sign
  assign a_lo = req.opa[31:0];
  assign b_lo = req.opb[31:0];
  assign a_hi = req.opa[64:32];
  assign b_hi = req.opb[64:32];

  assign pp_ll = {32'd0, a_lo} * {32'd0, b_lo};
  assign pp_lh = $signed({34'd0, a_lo}) * 66'(b_hi);
  assign pp_hl = 66'(a_hi) * $signed({34'd0, b_lo});
  assign pp_hh = 66'(a_hi) * 66'(b_hi);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1 <= '0;
    end else if (clk_en) begin
      s1.valid     <= req.valid;
      s1.ll        <= pp_ll;
      s1.lh        <= pp_lh;
      s1.hl        <= pp_hl;
      s1.hh        <= pp_hh;
      s1.sel       <= req.sel;
      s1.is_signed <= req.is_signed;
      s1.is_short  <= req.is_short;
      s1.swp_res   <= req.swp_res;
    end
  end

  // cross terms weigh 2^32, high term 2^64
  assign sum = $signed({66'd0, s1.ll})
             + (130'($signed(s1.lh)) <<< 32)
             + (130'($signed(s1.hl)) <<< 32)
             + (130'($signed(s1.hh)) <<< 64);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod <= '0;
    end else if (clk_en) begin
      prod.valid     <= s1.valid;
      prod.prod      <= sum;
      prod.sel       <= s1.sel;
      prod.is_signed <= s1.is_signed;
      prod.is_short  <= s1.is_short;
      prod.swp_res   <= s1.swp_res;
    end
  end

  // clk_en seen at the last STAGES edges
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ce_trk <= '0;
    end else begin
      ce_trk <= {ce_trk[STAGES-2:0], clk_en};
    end
  end

  // with every stage enabled, a valid leaves exactly STAGES edges after it entered
  a_array_latency: assert property (@(posedge clk) disable iff (!arst_n)
    &ce_trk |-> prod.valid == $past(req.valid, STAGES))
    else $error("imul_array: valid left the array at the wrong edge");

endmodule

/* hdl/imul_result.sv */
module imul_result (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                clk_en,
  input  imul_pkg::mul_prod_t prod,
  output imul_pkg::word_t     res,
  output imul_pkg::flags_t    flg,
  output logic                res_valid
);
  import imul_pkg::*;

  word_t       res_nxt;
  flags_t      flg_nxt;
  logic [65:0] disc64;
  logic [97:0] disc32;
  logic        ext64;
  logic        ext32;
  logic        lost64;
  logic        lost32;
  logic        cf;
  logic        sign_bit;

  always_comb begin
    case (prod.sel)
      SEL_LO: res_nxt = prod.prod[63:0];
      SEL_HI: res_nxt = prod.prod[127:64];
      SEL_LO32: res_nxt = {{32{prod.is_signed & prod.prod[31]}}, prod.prod[31:0]};
      SEL_SWP: res_nxt = prod.swp_res;
      default: res_nxt = prod.prod[63:0];
    endcase
  end

  // bits dropped above the kept width
  assign disc64 = prod.prod[129:64];
  assign disc32 = prod.prod[129:32];

  // what those bits must be if nothing was lost
  assign ext64 = prod.is_signed & prod.prod[63];
  assign ext32 = prod.is_signed & prod.prod[31];

  assign lost64 = disc64 != {66{ext64}};
  assign lost32 = disc32 != {98{ext32}};

  // 32x32 full products always fit, so the 64 bit check gives zero for them
  always_comb begin
    case (prod.sel)
      SEL_LO: cf = lost64;
      SEL_LO32: cf = lost32;
      default: cf = 1'b0;
    endcase
  end

  assign sign_bit = prod.is_short ? res_nxt[31] : res_nxt[63];

  always_comb begin
    flg_nxt          = '0;
    flg_nxt[FLG_CF]  = cf;
    flg_nxt[FLG_OF]  = cf;
    flg_nxt[FLG_RSV] = 1'b0;
    flg_nxt[FLG_SF]  = sign_bit;
    flg_nxt[FLG_ZF]  = ~|res_nxt;
    // even parity of the low byte
    flg_nxt[FLG_PF]  = ~^res_nxt[7:0];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res       <= '0;
      flg       <= '0;
      res_valid <= 1'b0;
    end else if (clk_en) begin
      res       <= res_nxt;
      flg       <= flg_nxt;
      res_valid <= prod.valid;
    end
  end

  // the high word slice needs bits 129 and 128 to be a plain extension
  a_prod_fits: assert property (@(posedge clk) disable iff (!arst_n)
    prod.valid |-> prod.prod[129:128] == (prod.is_signed ? {2{prod.prod[127]}} : 2'b00))
    else $error("imul_result: product does not fit in 128 bits");

endmodule

/* hdl/imul_unit.sv */
module imul_unit (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              clk_en,
  input  logic              en,
  input  imul_pkg::op_t     op,
  input  imul_pkg::word_t   a,
  input  imul_pkg::word_t   b,
  output imul_pkg::word_t   res,
  output imul_pkg::flags_t  flg,
  output logic              res_valid
);
  import imul_pkg::*;

  mul_req_t  req;
  mul_prod_t prod;

  // request register, opcode decode and swaps
  imul_decode i_imul_decode (
    .clk    (clk),
    .arst_n (arst_n),
    .clk_en (clk_en),
    .en     (en),
    .op     (op),
    .a      (a),
    .b      (b),
    .req    (req)
  );

  imul_array #(
    .STAGES (ARRAY_STAGES)
  ) i_imul_array (
    .clk    (clk),
    .arst_n (arst_n),
    .clk_en (clk_en),
    .req    (req),
    .prod   (prod)
  );

  imul_result i_imul_result (
    .clk       (clk),
    .arst_n    (arst_n),
    .clk_en    (clk_en),
    .prod      (prod),
    .res       (res),
    .flg       (flg),
    .res_valid (res_valid)
  );

endmodule

/* verification/imul_unit_tb.sv */
module imul_unit_tb;
  import imul_pkg::*;

  localparam int LATENCY = ARRAY_STAGES + 2;
  localparam int NUM_FIXED = 13;
  localparam int NUM_RAND = 40;
  localparam int NUM_ROWS = NUM_FIXED + NUM_RAND;
  localparam int DRAIN_TIMEOUT = 60;

  // stall is the number of cycles clk_en is held low after the row is issued
  typedef struct packed {
    op_t       op;
    word_t     a;
    word_t     b;
    logic [2:0] stall;
    word_t     res;
    flags_t    flg;
  } row_t;

  logic   clk;
  logic   arst_n;
  logic   clk_en;
  logic   en;
  op_t    op;
  word_t  a;
  word_t  b;
  word_t  res;
  flags_t flg;
  logic   res_valid;

  row_t rows [NUM_ROWS];
  int   row_q[$];
  int   edge_q[$];
  int   en_edges;
  int   seed;
  int   waited;

  imul_unit i_imul_unit (
    .clk       (clk),
    .arst_n    (arst_n),
    .clk_en    (clk_en),
    .en        (en),
    .op        (op),
    .a         (a),
    .b         (b),
    .res       (res),
    .flg       (flg),
    .res_valid (res_valid)
  );

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("error: %s expected 0x%h actual 0x%h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // full 128 bit product, then slice, extend and derive flags
  function automatic void model(input op_t mop, input word_t ma, input word_t mb,
                                output word_t r, output flags_t f);
    logic [127:0] p;
    logic [63:0]  p32;
    logic         lost;
    logic         sign;
    lost = 1'b0;
    p = {64'd0, ma} * {64'd0, mb};
    p32 = {32'd0, ma[31:0]} * {32'd0, mb[31:0]};
    case (mop)
      OP_IMUL64, OP_LIMUL64: p = {{64{ma[63]}}, ma} * {{64{mb[63]}}, mb};
      OP_IMUL32, OP_IMUL32_64: p32 = {{32{ma[31]}}, ma[31:0]} * {{32{mb[31]}}, mb[31:0]};
      default: ;
    endcase
    case (mop)
      OP_IMUL64: begin
        r = p[63:0];
        lost = p[127:64] != {64{p[63]}};
      end
      OP_LMUL64, OP_LIMUL64: r = p[127:64];
      OP_MUL32: begin
        r = {32'd0, p32[31:0]};
        lost = p32[63:32] != 32'd0;
      end
      OP_IMUL32: begin
        r = {{32{p32[31]}}, p32[31:0]};
        lost = p32[63:32] != {32{p32[31]}};
      end
      OP_MUL32_64, OP_IMUL32_64: r = p32;
      OP_SWP32: r = {32'd0, ma[7:0], ma[15:8], ma[23:16], ma[31:24]};
      OP_SWP64: r = {ma[7:0], ma[15:8], ma[23:16], ma[31:24],
                     ma[39:32], ma[47:40], ma[55:48], ma[63:56]};
      // mul64, illegal codes land here too
      default: begin
        r = p[63:0];
        lost = p[127:64] != 64'd0;
      end
    endcase
    sign = (mop == OP_MUL32 || mop == OP_IMUL32) ? r[31] : r[63];
    f = {lost, lost, 1'b0, sign, r == 64'd0, ~^r[7:0]};
  endfunction

  task automatic fill_table();
    word_t       r;
    flags_t      f;
    int unsigned u;
    rows[0]  = '{OP_MUL64, 64'h0, 64'h0, 3'd0, 64'h0, 6'h03};
    rows[1]  = '{OP_IMUL64, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 3'd0,
                 64'h8000_0000_0000_0000, 6'h35};
    rows[2]  = '{OP_MUL64, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 3'd0,
                 64'h1, 6'h30};
    rows[3]  = '{OP_LMUL64, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 3'd0,
                 64'hffff_ffff_ffff_fffe, 6'h04};
    rows[4]  = '{OP_SWP64, 64'h0123_4567_89ab_cdef, 64'h5, 3'd0,
                 64'hefcd_ab89_6745_2301, 6'h04};
    rows[5]  = '{OP_SWP32, 64'h0123_4567_89ab_cdef, 64'h5, 3'd0,
                 64'h0000_0000_efcd_ab89, 6'h00};
    rows[6]  = '{OP_IMUL32, 64'h0000_0000_7fff_ffff, 64'h2, 3'd0,
                 64'hffff_ffff_ffff_fffe, 6'h34};
    rows[7]  = '{OP_MUL32, 64'hdead_beef_ffff_ffff, 64'h0000_0000_ffff_ffff, 3'd0,
                 64'h1, 6'h30};
    rows[8]  = '{OP_IMUL32_64, 64'h0000_0000_ffff_ffff, 64'h1234_5678_ffff_ffff, 3'd0,
                 64'h1, 6'h00};
    rows[9]  = '{OP_MUL32_64, 64'h0000_0000_8000_0000, 64'h0000_0000_8000_0000, 3'd3,
                 64'h4000_0000_0000_0000, 6'h01};
    rows[10] = '{OP_LIMUL64, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 3'd0,
                 64'h0, 6'h03};
    rows[11] = '{OP_IMUL64, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 3'd0,
                 64'h1, 6'h00};
    rows[12] = '{OP_MUL32, 64'h0000_0001_0000_0000, 64'hffff_ffff_ffff_ffff, 3'd0,
                 64'h0, 6'h03};
    // hand values must agree with the model
    for (int i = 0; i < NUM_FIXED; i++) begin
      model(rows[i].op, rows[i].a, rows[i].b, r, f);
      check_value($sformatf("table row %0d res", i), rows[i].res, r);
      check_value($sformatf("table row %0d flg", i), 64'(rows[i].flg), 64'(f));
    end
    for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
      u = $unsigned($random(seed));
      rows[i].op = op_t'(u % 10);
      rows[i].a = {$random(seed), $random(seed)};
      rows[i].b = {$random(seed), $random(seed)};
      u = $unsigned($random(seed));
      rows[i].stall = (u % 6 == 0) ? 3'd2 : 3'd0;
      model(rows[i].op, rows[i].a, rows[i].b, r, f);
      rows[i].res = r;
      rows[i].flg = f;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // checks outputs after every enabled edge
  initial begin : monitor
    logic ce_seen;
    logic en_seen;
    logic rst_seen;
    logic due;
    en_edges = 0;
    forever begin
      @(posedge clk);
      ce_seen = clk_en;
      en_seen = en;
      rst_seen = arst_n;
      #10;
      if (rst_seen && ce_seen) begin
        if (en_seen) begin
          edge_q.push_back(en_edges);
        end
        en_edges++;
        due = edge_q.size() > 0 && edge_q[0] + LATENCY == en_edges;
        check_value($sformatf("res_valid at enabled edge %0d", en_edges),
                    64'(due), 64'(res_valid));
        if (due) begin
          check_value($sformatf("row %0d op %0d res", row_q[0], rows[row_q[0]].op),
                      rows[row_q[0]].res, res);
          check_value($sformatf("row %0d op %0d flg", row_q[0], rows[row_q[0]].op),
                      64'(rows[row_q[0]].flg), 64'(flg));
          void'(row_q.pop_front());
          void'(edge_q.pop_front());
        end
      end
    end
  end

  initial begin
    seed = 10419;
    arst_n = 1'b0;
    clk_en = 1'b0;
    en = 1'b0;
    op = OP_MUL64;
    a = '0;
    b = '0;
    fill_table();
    repeat (4) @(posedge clk);
    #2;
    check_value("res_valid in reset", 64'd0, 64'(res_valid));
    check_value("res in reset", 64'd0, res);
    check_value("flg in reset", 64'd0, 64'(flg));
    arst_n = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk);
      #2;
      clk_en = 1'b1;
      en = 1'b1;
      op = rows[i].op;
      a = rows[i].a;
      b = rows[i].b;
      row_q.push_back(i);
      // frozen cycles, en and new data must be ignored
      for (int s = 0; s < int'(rows[i].stall); s++) begin
        @(posedge clk);
        #2;
        clk_en = 1'b0;
        a = ~rows[i].a;
      end
    end
    @(posedge clk);
    #2;
    en = 1'b0;
    clk_en = 1'b1;
    waited = 0;
    while (row_q.size() != 0) begin
      if (waited == DRAIN_TIMEOUT) begin
        $display("timeout: %0d results did not come out", row_q.size());
        $display("Verification failed");
        $fatal(1, "drain timeout");
      end else begin
        @(posedge clk);
        waited++;
      end
    end
    // no stray res_valid after the last result
    repeat (LATENCY + 2) @(posedge clk);
    #11;
    $display("Verification passed");
    $finish;
  end

endmodule

/* vlog.f */
hdl/imul_pkg.sv
hdl/imul_decode.sv
hdl/imul_array.sv
hdl/imul_result.sv
hdl/imul_unit.sv
verification/imul_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module imul_unit_tb \
  -Mdir "$build_dir" \
  -o imul_unit_tb
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

"./$build_dir/imul_unit_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" "$log_file"; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi
